// ==== list.f ====
design/vec_cfg_pkg.sv
design/vset_decoder.sv
design/vector_csrs.sv
design/vcsr_read_port.sv
design/vec_config_unit.sv
verif/vec_config_tb.sv

// ==== Bender.yml ====
package:
  name: vec_cfg_pkg

sources:
  # Shared types first, then the RTL blocks and the top level.
  - files:
      - design/vec_cfg_pkg.sv
      - design/vset_decoder.sv
      - design/vector_csrs.sv
      - design/vcsr_read_port.sv
      - design/vec_config_unit.sv

  # Testbench, only for simulation.
  - target: test
    files:
      - verif/vec_config_tb.sv

// ==== verif/vec_config_tb.sv ====
`timescale 1ns/1ps

module vec_config_tb;
    import vec_cfg_pkg::*;

    localparam int VLEN         = 128;
    localparam int ELEN         = 32;
    localparam int VL_W         = $clog2(VLEN + 1);
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;

    // Sweep, vsetivli, vsetvl, rs1/rd special cases, illegal settings.
    localparam int NUM_ISSUE   = 84 + 20 + 24 + 16 + 11;
    // Reset read, sweep reads, vsetvl reads, special reads, illegal reads, CSR test.
    localparam int NUM_READ    = 1 + 21 + 24 + 8 + 22 + 19;
    localparam int NUM_IDLE    = RESET_CYCLES + 6;
    localparam int CYCLE_LIMIT = NUM_ISSUE + NUM_READ + NUM_IDLE + 200;

    // Expected state after one request.
    typedef struct packed {
        vtype_t          vtype;
        logic [VL_W-1:0] vl;
        logic            we;
        logic [4:0]      addr;
    } expect_t;

    logic            clk;
    logic            reset_n;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [31:0]     rs1_value_i;
    logic [31:0]     rs2_value_i;
    logic            rd_we_o;
    logic [4:0]      rd_addr_o;
    logic [31:0]     rd_data_o;
    vsew_e           vsew_o;
    vlmul_e          vlmul_o;
    logic [VL_W-1:0] vl_o;
    logic [11:0]     csr_addr_i;
    logic [31:0]     csr_rdata_o;
    logic            csr_illegal_o;

    logic [31:0]     lfsr_state = 32'hb60a_54c0;
    vtype_t          shadow_vtype;
    logic [VL_W-1:0] shadow_vl;
    expect_t         exp_q[$];
    int              cycle_count;
    int              err_vtype;
    int              err_vl;
    int              err_wb;
    int              err_csr;

    vec_config_unit #(
        .VLEN (VLEN),
        .ELEN (ELEN)
    ) DUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_value_i   (rs1_value_i),
        .rs2_value_i   (rs2_value_i),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .vsew_o        (vsew_o),
        .vlmul_o       (vlmul_o),
        .vl_o          (vl_o),
        .csr_addr_i    (csr_addr_i),
        .csr_rdata_o   (csr_rdata_o),
        .csr_illegal_o (csr_illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_nz_reg();
        logic [4:0] r;
        r = rand_bits(5);
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    // Random vma/vta with a legal width and grouping.
    function automatic logic [7:0] legal_vt();
        logic [1:0] ma_ta;
        logic [2:0] sew;
        logic [2:0] lmul;
        ma_ta = rand_bits(2);
        sew   = rand_bits(2) % 3;
        lmul  = rand_bits(3);
        if (lmul == 3'd4) begin
            lmul = 3'd0;
        end
        return {ma_ta, sew, lmul};
    endfunction

    function automatic expect_t vcfg_model(input vset_op_e kind, input logic [4:0] rs1_idx,
                                           input logic [4:0] rd_idx, input logic [7:0] vt_bits,
                                           input logic [31:0] rs1_val,
                                           input logic [VL_W-1:0] old_vl);
        expect_t res;
        int      sew;
        int      lmul_num;
        int      lmul_den;
        int      vlmax;
        longint  avl;
        res      = '0;
        res.we   = (rd_idx != 5'd0);
        res.addr = rd_idx;
        sew      = 8 << vt_bits[5:3];
        if (vt_bits[2:0] == 3'd4 || vt_bits[5:3] >= 3'd4 || sew > ELEN) begin
            res.vtype.vill = 1'b1;                       // Everything else stays zero.
        end else begin
            if (vt_bits[2]) begin
                lmul_num = 1;
                lmul_den = 1 << (8 - vt_bits[2:0]);
            end else begin
                lmul_num = 1 << vt_bits[1:0];
                lmul_den = 1;
            end
            vlmax = (VLEN * lmul_num) / (sew * lmul_den);
            if (kind == VSETIVLI) begin
                avl = rs1_idx;
            end else if (rs1_idx != 5'd0) begin
                avl = rs1_val;
            end else if (rd_idx != 5'd0) begin
                avl = 64'hFFFF_FFFF;
            end else begin
                avl = old_vl;
            end
            res.vl          = (avl < vlmax) ? avl : vlmax;
            res.vtype.vma   = vt_bits[7];
            res.vtype.vta   = vt_bits[6];
            res.vtype.vsew  = vsew_e'(vt_bits[5:3]);
            res.vtype.vlmul = vlmul_e'(vt_bits[2:0]);
        end
        return res;
    endfunction

    task automatic check_vtype(input string name, input vtype_t exp, input vtype_t got);
        if (got !== exp) begin
            err_vtype++;
            $display("FAILED %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_vl(input logic [VL_W-1:0] exp);
        if (vl_o !== exp) begin
            err_vl++;
            $display("FAILED %0t: vl_o expected %0d got %0d", $time, exp, vl_o);
        end
    endtask

    task automatic check_wb(input logic exp_we, input logic [4:0] exp_addr,
                            input logic [31:0] exp_data);
        if (rd_we_o !== exp_we) begin
            err_wb++;
            $display("FAILED %0t: rd_we_o expected %b got %b", $time, exp_we, rd_we_o);
        end else if (exp_we && rd_addr_o !== exp_addr) begin
            err_wb++;
            $display("FAILED %0t: rd_addr_o expected %0d got %0d", $time, exp_addr, rd_addr_o);
        end else if (exp_we && rd_data_o !== exp_data) begin
            err_wb++;
            $display("FAILED %0t: rd_data_o expected %0d got %0d", $time, exp_data, rd_data_o);
        end
    endtask

    task automatic check_csr(input logic [11:0] addr, input logic [31:0] exp_data,
                             input logic exp_illegal);
        if (csr_rdata_o !== exp_data) begin
            err_csr++;
            $display("FAILED %0t: csr_rdata_o at %h expected %h got %h",
                     $time, addr, exp_data, csr_rdata_o);
        end
        if (csr_illegal_o !== exp_illegal) begin
            err_csr++;
            $display("FAILED %0t: csr_illegal_o at %h expected %b got %b",
                     $time, addr, exp_illegal, csr_illegal_o);
        end
    endtask

    task automatic issue(input vset_op_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [7:0] vt_bits, input logic [31:0] avl_value);
        logic [31:0] word;
        logic [31:0] rs2_val;
        logic [2:0]  hi;
        logic [4:0]  rs2_idx;
        expect_t     exp;
        hi      = rand_bits(3);                          // Requested vill and reserved bits.
        rs2_idx = rand_bits(5);
        rs2_val = {24'(rand_bits(24)), vt_bits};
        case (kind)
            VSETIVLI: word = {2'b11, hi[1:0], vt_bits, rs1, F3_OPCFG, rd, OPC_OP_V};
            VSETVL:   word = {7'b1000000, rs2_idx, rs1, F3_OPCFG, rd, OPC_OP_V};
            default:  word = {1'b0, hi, vt_bits, rs1, F3_OPCFG, rd, OPC_OP_V};
        endcase
        exp = vcfg_model(kind, rs1, rd, vt_bits, avl_value, shadow_vl);
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid_i = 1'b1;
        instr_i       = word;
        rs1_value_i   = avl_value;
        rs2_value_i   = rs2_val;
        exp_q.push_back(exp);
        shadow_vtype  = exp.vtype;
        shadow_vl     = exp.vl;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
            instr_valid_i = 1'b0;
        end
    endtask

    task automatic read_csr(input logic [11:0] addr);
        logic [31:0] exp_data;
        logic        exp_illegal;
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid_i = 1'b0;
        csr_addr_i    = addr;
        exp_illegal   = 1'b0;
        case (addr)
            CSR_VL:    exp_data = {{(32 - VL_W){1'b0}}, shadow_vl};
            CSR_VTYPE: exp_data = {shadow_vtype.vill, 23'b0, shadow_vtype.vma, shadow_vtype.vta,
                                   shadow_vtype.vsew, shadow_vtype.vlmul};
            CSR_VLENB: exp_data = VLEN / 8;
            default: begin
                exp_data    = '0;
                exp_illegal = 1'b1;
            end
        endcase
        @(negedge clk);
        check_csr(addr, exp_data, exp_illegal);
    endtask

    // Results of a request are visible one cycle after it was driven.
    always @(negedge clk) begin : compare
        vtype_t         got;
        static logic    due_valid = 1'b0;
        static expect_t due = '0;
        static expect_t held = '0;
        if (reset_n) begin
            if (due_valid) begin
                held = due;
            end
            got       = held.vtype;                      // vill, vma, vta are seen by CSR reads.
            got.vsew  = vsew_o;
            got.vlmul = vlmul_o;
            check_vtype("vsew_o/vlmul_o", held.vtype, got);
            check_vl(held.vl);
            check_wb(due_valid && due.we, due.addr, {{(32 - VL_W){1'b0}}, held.vl});
            due_valid = (exp_q.size() != 0);
            if (due_valid) begin
                due = exp_q.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [11:0] addr;
        reset_n       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_value_i   = '0;
        rs2_value_i   = '0;
        csr_addr_i    = CSR_VL;
        shadow_vtype  = '0;
        shadow_vl     = '0;
        cycle_count   = 0;
        err_vtype     = 0;
        err_vl        = 0;
        err_wb        = 0;
        err_csr       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        idle(2);
        read_csr(CSR_VTYPE);

        // Register AVL over every legal width and grouping.
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 8; l++) begin
                if (l != 4) begin
                    repeat (4) begin
                        issue(VSETVLI, rand_nz_reg(), rand_nz_reg(),
                              {2'(rand_bits(2)), 3'(s), 3'(l)}, rand_bits(9) % 301);
                    end
                    read_csr(CSR_VL);
                end
            end
        end

        repeat (20) issue(VSETIVLI, rand_nz_reg(), 5'(rand_bits(5)), legal_vt(), rand_bits(32));

        // vsetvl, every sixth one writes x0.
        for (int i = 0; i < 24; i++) begin
            issue(VSETVL, (i % 6 == 0) ? 5'd0 : rand_nz_reg(), rand_nz_reg(), legal_vt(),
                  rand_bits(9) % 301);
            read_csr(CSR_VTYPE);
        end

        // rs1 = x0 asks for VLMAX, then both x0 keeps vl under the new grouping.
        repeat (8) begin
            issue(VSETVLI, rand_nz_reg(), 5'd0, legal_vt(), rand_bits(32));
            issue(VSETVLI, 5'd0, 5'd0, legal_vt(), rand_bits(32));
            read_csr(CSR_VL);
        end

        for (int i = 0; i < 11; i++) begin
            if (i < 3) begin
                issue(VSETVLI, rand_nz_reg(), rand_nz_reg(), {2'b11, 3'(i), 3'd4}, 32'd7);
            end else if (i < 7) begin
                issue(VSETVLI, rand_nz_reg(), rand_nz_reg(), {2'b01, 3'(i + 1), 3'd1}, 32'd7);
            end else begin
                issue(VSETVLI, rand_nz_reg(), rand_nz_reg(), {2'b10, 3'd3, 3'(i - 7)}, 32'd7);
            end
            read_csr(CSR_VTYPE);
            read_csr(CSR_VL);
        end

        read_csr(CSR_VL);
        read_csr(CSR_VTYPE);
        read_csr(CSR_VLENB);
        repeat (16) begin
            addr = rand_bits(12);
            if (addr >= CSR_VL && addr <= CSR_VLENB) begin
                addr[8] = ~addr[8];                      // Move off the known addresses.
            end
            read_csr(addr);
        end

        idle(4);
        $display("Errors: vtype %0d, vl %0d, write-back %0d, csr %0d",
                 err_vtype, err_vl, err_wb, err_csr);
        if (err_vtype + err_vl + err_wb + err_csr == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== design/vec_config_unit.sv ====
`timescale 1ns/1ps

module vec_config_unit #(
    parameter int  VLEN = 128,
    parameter int  ELEN = 32,
    localparam int VL_W = $clog2(VLEN + 1)
) (
    input  logic                clk,
    input  logic                reset_n,

    input  logic                instr_valid_i,
    input  logic [31:0]         instr_i,
    input  logic [31:0]         rs1_value_i,
    input  logic [31:0]         rs2_value_i,

    output logic                rd_we_o,
    output logic [4:0]          rd_addr_o,
    output logic [31:0]         rd_data_o,

    output vec_cfg_pkg::vsew_e  vsew_o,
    output vec_cfg_pkg::vlmul_e vlmul_o,
    output logic [VL_W-1:0]     vl_o,

    input  logic [11:0]         csr_addr_i,
    output logic [31:0]         csr_rdata_o,
    output logic                csr_illegal_o
);
    import vec_cfg_pkg::*;

    vset_req_t       req;
    vtype_t          vtype;
    logic [VL_W-1:0] vl;

    vset_decoder u_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .req_o         (req)
    );

    vector_csrs #(
        .VLEN (VLEN),
        .ELEN (ELEN)
    ) u_csrs (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_i       (req),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .vtype_o     (vtype),
        .vl_o        (vl),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o)
    );

    vcsr_read_port #(
        .VLEN (VLEN)
    ) u_read_port (
        .csr_addr_i    (csr_addr_i),
        .vtype_i       (vtype),
        .vl_i          (vl),
        .csr_rdata_o   (csr_rdata_o),
        .csr_illegal_o (csr_illegal_o)
    );

    assign vsew_o  = vtype.vsew;                        // To the datapath.
    assign vlmul_o = vtype.vlmul;
    assign vl_o    = vl;

endmodule

// ==== design/vcsr_read_port.sv ====
`timescale 1ns/1ps

module vcsr_read_port #(
    parameter int  VLEN = 128,
    localparam int VL_W = $clog2(VLEN + 1)
) (
    input  logic [11:0]         csr_addr_i,
    input  vec_cfg_pkg::vtype_t vtype_i,
    input  logic [VL_W-1:0]     vl_i,
    output logic [31:0]         csr_rdata_o,
    output logic                csr_illegal_o
);
    import vec_cfg_pkg::*;

    localparam int VLENB = VLEN / 8;

    logic [31:0] vtype_word;
    logic [31:0] vl_word;
    logic [31:0] vlenb_word;

    // CSR layout keeps vill at the top and the fields in the low byte.
    assign vtype_word = {vtype_i.vill,
                         23'b0,
                         vtype_i.vma,
                         vtype_i.vta,
                         vtype_i.vsew,
                         vtype_i.vlmul};

    assign vl_word    = {{(32 - VL_W){1'b0}}, vl_i};
    assign vlenb_word = VLENB;

    // Plain address decode, no read strobe.
    always_comb begin
        csr_rdata_o   = '0;
        csr_illegal_o = 1'b0;
        case (csr_addr_i)
            CSR_VL: begin
                csr_rdata_o = vl_word;
            end
            CSR_VTYPE: begin
                csr_rdata_o = vtype_word;
            end
            CSR_VLENB: begin
                csr_rdata_o = vlenb_word;
            end
            default: begin
                csr_illegal_o = 1'b1;                   // Data stays zero.
            end
        endcase
    end

endmodule

// ==== design/vector_csrs.sv ====
`timescale 1ns/1ps

module vector_csrs #(
    parameter int  VLEN = 128,
    parameter int  ELEN = 32,
    localparam int VL_W = $clog2(VLEN + 1)
) (
    input  logic                   clk,
    input  logic                   reset_n,

    input  vec_cfg_pkg::vset_req_t req_i,
    input  logic [31:0]            rs1_value_i,
    input  logic [31:0]            rs2_value_i,

    output vec_cfg_pkg::vtype_t    vtype_o,
    output logic [VL_W-1:0]        vl_o,

    output logic                   rd_we_o,
    output logic [4:0]             rd_addr_o,
    output logic [31:0]            rd_data_o
);
    import vec_cfg_pkg::*;

    localparam int VLENB = VLEN / 8;

    logic [7:0]      vtype_bits;
    logic [2:0]      sew_code;
    logic [2:0]      lmul_code;
    logic [31:0]     sew_width;
    logic            illegal;
    logic [31:0]     elems_per_reg;
    logic [31:0]     vlmax_wide;
    logic [VL_W-1:0] vlmax;
    logic [31:0]     avl;
    logic [VL_W-1:0] vl_next;
    vtype_t          vtype_next;
    logic            req_active;

    vtype_t          vtype_q;
    logic [VL_W-1:0] vl_q;
    logic            rd_we_q;
    logic [4:0]      rd_addr_q;

    assign req_active = (req_i.op != VSET_NONE);

    // vill request bit is dropped, legality is decided here.
    assign vtype_bits = (req_i.op == VSETVL) ? rs2_value_i[7:0] : req_i.zimm[7:0];
    assign sew_code   = vtype_bits[5:3];
    assign lmul_code  = vtype_bits[2:0];

    assign sew_width = 32'd8 << sew_code[1:0];

    assign illegal = (lmul_code == LMUL_RSV) ||
                     sew_code[2] ||                     // Reserved widths.
                     (sew_width > ELEN);

    // Elements per register, then scaled by the grouping.
    assign elems_per_reg = VLENB >> sew_code;

    always_comb begin
        if (lmul_code[2]) begin
            vlmax_wide = elems_per_reg >> (4'd8 - {1'b0, lmul_code});  // Fractional.
        end else begin
            vlmax_wide = elems_per_reg << lmul_code[1:0];
        end
    end

    assign vlmax = vlmax_wide[VL_W-1:0];                // VLEN is the largest value.

    // AVL source.
    always_comb begin
        if (req_i.op == VSETIVLI) begin
            avl = {27'b0, req_i.rs1_idx};
        end else if (req_i.rs1_idx != '0) begin
            avl = rs1_value_i;
        end else if (req_i.rd_idx != '0) begin
            avl = '1;                                   // Ask for VLMAX.
        end else begin
            avl = {{(32 - VL_W){1'b0}}, vl_q};          // Keep current vl.
        end
    end

    always_comb begin
        if (illegal) begin
            vl_next    = '0;
            vtype_next = '0;
            vtype_next.vill = 1'b1;
        end else begin
            if (avl < {{(32 - VL_W){1'b0}}, vlmax}) begin
                vl_next = avl[VL_W-1:0];
            end else begin
                vl_next = vlmax;
            end
            vtype_next.vill  = 1'b0;
            vtype_next.vma   = vtype_bits[7];
            vtype_next.vta   = vtype_bits[6];
            vtype_next.vsew  = vsew_e'(sew_code);
            vtype_next.vlmul = vlmul_e'(lmul_code);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vtype_q <= '0;                              // EW8, LMUL_1, legal.
            vl_q    <= '0;
            rd_we_q <= 1'b0;
        end else begin
            rd_we_q <= req_active && (req_i.rd_idx != '0);
            if (req_active) begin
                vtype_q <= vtype_next;
                vl_q    <= vl_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_active) begin
            rd_addr_q <= req_i.rd_idx;
        end
    end

    assign vtype_o   = vtype_q;
    assign vl_o      = vl_q;
    assign rd_we_o   = rd_we_q;
    assign rd_addr_o = rd_addr_q;
    assign rd_data_o = {{(32 - VL_W){1'b0}}, vl_q};    // New vl, one cycle later.

endmodule

// ==== design/vset_decoder.sv ====
`timescale 1ns/1ps

module vset_decoder (
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    output vec_cfg_pkg::vset_req_t req_o
);
    import vec_cfg_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_cfg;
    vset_op_e   op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    // Only a valid OP-V word with the configuration funct3 is considered.
    assign is_cfg = instr_valid_i && (opcode == OPC_OP_V) && (funct3 == F3_OPCFG);

    // Form is chosen by the top bits of the word.
    always_comb begin
        op = VSET_NONE;
        if (is_cfg) begin
            if (!instr_i[31]) begin
                op = VSETVLI;                       // 11-bit zimm form.
            end else if (instr_i[31:30] == 2'b11) begin
                op = VSETIVLI;                      // 10-bit zimm, 5-bit uimm AVL.
            end else if (instr_i[31:25] == 7'b1000000) begin
                op = VSETVL;                        // vtype from rs2.
            end
        end
    end

    // Field extraction per instruction form.
    always_comb begin
        req_o.op      = op;
        req_o.rs1_idx = instr_i[19:15];             // rs1 or uimm.
        req_o.rd_idx  = instr_i[11:7];
        case (op)
            VSETVLI: begin
                req_o.zimm = instr_i[30:20];
            end
            VSETIVLI: begin
                req_o.zimm = {1'b0, instr_i[29:20]};
            end
            default: begin
                req_o.zimm = '0;                    // Not used by vsetvl.
            end
        endcase
    end

endmodule

// ==== design/vec_cfg_pkg.sv ====
package vec_cfg_pkg;

    // Kind of configuration request seen by the decoder.
    typedef enum logic [1:0] {
        VSET_NONE = 2'd0,
        VSETVLI   = 2'd1,
        VSETIVLI  = 2'd2,
        VSETVL    = 2'd3
    } vset_op_e;

    // Selected element width; codes 4 to 7 are reserved.
    typedef enum logic [2:0] {
        EW8  = 3'd0,
        EW16 = 3'd1,
        EW32 = 3'd2,
        EW64 = 3'd3
    } vsew_e;

    // Register grouping, integer and fractional.
    typedef enum logic [2:0] {
        LMUL_1   = 3'd0,
        LMUL_2   = 3'd1,
        LMUL_4   = 3'd2,
        LMUL_8   = 3'd3,
        LMUL_RSV = 3'd4,
        LMUL_F8  = 3'd5,
        LMUL_F4  = 3'd6,
        LMUL_F2  = 3'd7
    } vlmul_e;

    // Decoded request handed to the register block.
    typedef struct packed {
        vset_op_e    op;
        logic [4:0]  rs1_idx;            // Immediate AVL for vsetivli.
        logic [4:0]  rd_idx;
        logic [10:0] zimm;               // Bit 10 is zero for vsetivli.
    } vset_req_t;

    // Architectural vtype, without the reserved middle bits.
    typedef struct packed {
        logic   vill;
        logic   vma;
        logic   vta;
        vsew_e  vsew;
        vlmul_e vlmul;
    } vtype_t;

    // Read-only vector CSR addresses.
    localparam logic [11:0] CSR_VL    = 12'hC20;
    localparam logic [11:0] CSR_VTYPE = 12'hC21;
    localparam logic [11:0] CSR_VLENB = 12'hC22;

    // OP-V major opcode and the configuration funct3.
    localparam logic [6:0] OPC_OP_V = 7'b1010111;
    localparam logic [2:0] F3_OPCFG = 3'b111;

endpackage
